/* include/mips_lite_macros.svh */
`ifndef MIPS_LITE_MACROS_SVH
`define MIPS_LITE_MACROS_SVH

`define MIPS_WORD_W      32
`define MIPS_REG_NUM     32
`define MIPS_REG_ADDR_W  5

// primary opcode field, instr[31:26]
`define OP_SPECIAL  6'b000000
`define OP_ADDIU    6'b001001
`define OP_SLTI     6'b001010
`define OP_SLTIU    6'b001011
`define OP_ANDI     6'b001100
`define OP_ORI      6'b001101
`define OP_XORI     6'b001110
`define OP_LUI      6'b001111

// function field of SPECIAL, instr[5:0]
`define FN_SLL   6'b000000
`define FN_SRL   6'b000010
`define FN_SRA   6'b000011
`define FN_SLLV  6'b000100
`define FN_SRLV  6'b000110
`define FN_SRAV  6'b000111
`define FN_ADDU  6'b100001
`define FN_SUBU  6'b100011
`define FN_AND   6'b100100
`define FN_OR    6'b100101
`define FN_XOR   6'b100110
`define FN_NOR   6'b100111
`define FN_SLT   6'b101010
`define FN_SLTU  6'b101011

`endif

/* hdl/mips_lite_pkg.sv */
`default_nettype none

`include "mips_lite_macros.svh"

package mips_lite_pkg;

    typedef logic [`MIPS_WORD_W-1:0]     word_t;      // data or instruction word
    typedef logic [`MIPS_REG_ADDR_W-1:0] reg_addr_t;  // register index

    // operation carried from decode to execute
    typedef enum logic [3:0] {
        NOP,
        OR,
        AND,
        XOR,
        NOR,
        SLL,
        SRL,
        SRA,
        ADDU,
        SUBU,
        SLT,
        SLTU
    } alu_op_e;

    // decoder output, still holding register indices
    typedef struct packed {
        alu_op_e   alu_op;
        logic      rs_rd_en;     // src1 comes from rs
        logic      rt_rd_en;     // src2 comes from rt
        reg_addr_t rs_addr;
        reg_addr_t rt_addr;
        reg_addr_t dest_addr;
        logic      wr_en;
        word_t     imm;          // extended immediate or shamt
        logic      imm_is_src1;  // fixed shift, imm is the amount
    } decoded_t;

    // operands resolved, ready for the ALU
    typedef struct packed {
        alu_op_e   alu_op;
        word_t     src1;
        word_t     src2;
        reg_addr_t dest_addr;
        logic      wr_en;
    } ex_req_t;

    // one register write, also used as a forwarding source
    typedef struct packed {
        logic      wr_en;
        reg_addr_t dest_addr;
        word_t     result;
    } wb_res_t;

endpackage

`default_nettype wire

/* hdl/instr_fetch_wb.sv */
`timescale 1ns/1ns
`default_nettype none

module instr_fetch_wb (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 wb_cyc_i,
    input  logic                 wb_stb_i,
    input  logic                 wb_we_i,
    input  mips_lite_pkg::word_t wb_dat_i,
    output logic                 wb_ack_o,
    output mips_lite_pkg::word_t wb_dat_o,
    output mips_lite_pkg::word_t instr_o,
    output logic                 instr_vld_o
);

    logic accept;  // write taken on this edge

    // never stalls, so every strobe is answered at once
    assign wb_ack_o = wb_cyc_i & wb_stb_i & rst_n_i;
    assign accept   = wb_ack_o & wb_we_i;
    assign wb_dat_o = '0;  // nothing readable behind the port

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            instr_vld_o <= 1'b0;
        end else begin
            instr_vld_o <= accept;  // one decode slot per word
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            instr_o <= wb_dat_i;
        end
    end

endmodule

`default_nettype wire

/* hdl/id_decode.sv */
`include "mips_lite_macros.svh"
`timescale 1ns/1ns
`default_nettype none

module id_decode (
    input  mips_lite_pkg::word_t    instr_i,
    input  logic                    instr_vld_i,
    output mips_lite_pkg::decoded_t dec_o
);

    import mips_lite_pkg::*;

    logic [5:0]  op;
    logic [5:0]  fn;
    reg_addr_t   rs;
    reg_addr_t   rt;
    reg_addr_t   rd;
    logic [4:0]  shamt;
    logic [15:0] imm16;
    word_t       imm_zext;
    word_t       imm_sext;
    alu_op_e     r_op;     // SPECIAL function mapped to an operation
    logic        r_fixed;  // sll/srl/sra with shamt field
    logic        known;    // legal, kept encoding

    assign op       = instr_i[31:26];
    assign rs       = instr_i[25:21];
    assign rt       = instr_i[20:16];
    assign rd       = instr_i[15:11];
    assign shamt    = instr_i[10:6];
    assign fn       = instr_i[5:0];
    assign imm16    = instr_i[15:0];
    assign imm_zext = {16'h0000, imm16};
    assign imm_sext = {{16{imm16[15]}}, imm16};

    always_comb begin
        r_fixed = 1'b0;
        case (fn)
            `FN_OR:   r_op = OR;
            `FN_AND:  r_op = AND;
            `FN_XOR:  r_op = XOR;
            `FN_NOR:  r_op = NOR;
            `FN_SLLV: r_op = SLL;
            `FN_SRLV: r_op = SRL;
            `FN_SRAV: r_op = SRA;
            `FN_ADDU: r_op = ADDU;
            `FN_SUBU: r_op = SUBU;
            `FN_SLT:  r_op = SLT;
            `FN_SLTU: r_op = SLTU;
            `FN_SLL: begin
                r_op    = SLL;
                r_fixed = 1'b1;
            end
            `FN_SRL: begin
                r_op    = SRL;
                r_fixed = 1'b1;
            end
            `FN_SRA: begin
                r_op    = SRA;
                r_fixed = 1'b1;
            end
            default: r_op = NOP;  // jr, mult, sync and the rest
        endcase
    end

    always_comb begin
        dec_o             = '0;
        dec_o.alu_op      = NOP;
        dec_o.rs_addr     = rs;
        dec_o.rt_addr     = rt;
        dec_o.dest_addr   = rt;  // I-type writes rt
        known             = 1'b0;

        case (op)
            `OP_SPECIAL: begin
                dec_o.dest_addr = rd;
                // unused field must be zero, as in the full ISA
                if (r_op != NOP && (r_fixed ? (rs == '0) : (shamt == '0))) begin
                    known             = 1'b1;
                    dec_o.alu_op      = r_op;
                    dec_o.rs_rd_en    = ~r_fixed;
                    dec_o.rt_rd_en    = 1'b1;
                    dec_o.imm_is_src1 = r_fixed;
                    dec_o.imm         = r_fixed ? word_t'(shamt) : '0;
                end
            end
            `OP_ORI: begin
                dec_o.alu_op = OR;
                dec_o.imm    = imm_zext;
            end
            `OP_ANDI: begin
                dec_o.alu_op = AND;
                dec_o.imm    = imm_zext;
            end
            `OP_XORI: begin
                dec_o.alu_op = XOR;
                dec_o.imm    = imm_zext;
            end
            `OP_LUI: begin
                dec_o.alu_op = OR;  // 0 | (imm << 16)
                dec_o.imm    = {imm16, 16'h0000};
            end
            `OP_ADDIU: begin
                dec_o.alu_op = ADDU;
                dec_o.imm    = imm_sext;
            end
            `OP_SLTI: begin
                dec_o.alu_op = SLT;
                dec_o.imm    = imm_sext;
            end
            `OP_SLTIU: begin
                dec_o.alu_op = SLTU;  // sign-extended, compared unsigned
                dec_o.imm    = imm_sext;
            end
            default: begin
            end
        endcase

        if (op != `OP_SPECIAL && dec_o.alu_op != NOP) begin
            known          = 1'b1;
            dec_o.rs_rd_en = (op != `OP_LUI);  // lui ignores rs
        end

        dec_o.wr_en = known & instr_vld_i & (dec_o.dest_addr != '0);
    end

endmodule

`default_nettype wire

/* hdl/id_operand_sel.sv */
`timescale 1ns/1ns
`default_nettype none

module id_operand_sel (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  mips_lite_pkg::decoded_t dec_i,
    output mips_lite_pkg::reg_addr_t rf_rs_addr_o,
    output mips_lite_pkg::reg_addr_t rf_rt_addr_o,
    input  mips_lite_pkg::word_t    rf_rs_data_i,
    input  mips_lite_pkg::word_t    rf_rt_data_i,
    input  mips_lite_pkg::wb_res_t  ex_fwd_i,
    input  mips_lite_pkg::wb_res_t  wb_fwd_i,
    output mips_lite_pkg::ex_req_t  req_o
);

    import mips_lite_pkg::*;

    word_t rs_val;
    word_t rt_val;
    word_t src1;
    word_t src2;

    // youngest producer wins; r0 is never taken from a bypass
    function automatic word_t fwd_pick(
        input reg_addr_t addr,
        input word_t     rf_data,
        input wb_res_t   ex_f,
        input wb_res_t   wb_f
    );
        word_t val;
        if (addr == '0) begin
            val = '0;
        end else if (ex_f.wr_en && ex_f.dest_addr == addr) begin
            val = ex_f.result;
        end else if (wb_f.wr_en && wb_f.dest_addr == addr) begin
            val = wb_f.result;  // not yet in the regfile
        end else begin
            val = rf_data;
        end
        return val;
    endfunction

    assign rf_rs_addr_o = dec_i.rs_addr;
    assign rf_rt_addr_o = dec_i.rt_addr;

    assign rs_val = fwd_pick(dec_i.rs_addr, rf_rs_data_i, ex_fwd_i, wb_fwd_i);
    assign rt_val = fwd_pick(dec_i.rt_addr, rf_rt_data_i, ex_fwd_i, wb_fwd_i);

    // fixed shifts put shamt in src1, other immediates go to src2
    assign src1 = dec_i.rs_rd_en    ? rs_val :
                  dec_i.imm_is_src1 ? dec_i.imm : '0;
    assign src2 = dec_i.rt_rd_en    ? rt_val : dec_i.imm;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            req_o <= '0;
        end else begin
            req_o.alu_op    <= dec_i.alu_op;
            req_o.src1      <= src1;
            req_o.src2      <= src2;
            req_o.dest_addr <= dec_i.dest_addr;
            req_o.wr_en     <= dec_i.wr_en;
        end
    end

endmodule

`default_nettype wire

/* hdl/ex_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module ex_stage (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  mips_lite_pkg::ex_req_t req_i,
    output mips_lite_pkg::wb_res_t ex_fwd_o,
    output mips_lite_pkg::wb_res_t wb_res_o
);

    import mips_lite_pkg::*;

    logic [4:0] shamt;  // low bits of src1, for both shift forms
    word_t      result;
    logic       lt_s;
    logic       lt_u;

    assign shamt = req_i.src1[4:0];
    assign lt_s  = $signed(req_i.src1) < $signed(req_i.src2);
    assign lt_u  = req_i.src1 < req_i.src2;

    always_comb begin
        case (req_i.alu_op)
            OR:      result = req_i.src1 | req_i.src2;
            AND:     result = req_i.src1 & req_i.src2;
            XOR:     result = req_i.src1 ^ req_i.src2;
            NOR:     result = ~(req_i.src1 | req_i.src2);
            SLL:     result = req_i.src2 << shamt;
            SRL:     result = req_i.src2 >> shamt;
            SRA:     result = $signed(req_i.src2) >>> shamt;  // keeps the sign
            ADDU:    result = req_i.src1 + req_i.src2;        // wraps, no trap
            SUBU:    result = req_i.src1 - req_i.src2;
            SLT:     result = word_t'(lt_s);
            SLTU:    result = word_t'(lt_u);
            default: result = '0;
        endcase
    end

    // bypass for the instruction now in decode
    assign ex_fwd_o.wr_en     = req_i.wr_en;
    assign ex_fwd_o.dest_addr = req_i.dest_addr;
    assign ex_fwd_o.result    = result;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wb_res_o <= '0;
        end else begin
            wb_res_o <= ex_fwd_o;  // write-back record
        end
    end

endmodule

`default_nettype wire

/* hdl/regfile.sv */
`include "mips_lite_macros.svh"
`timescale 1ns/1ns
`default_nettype none

module regfile (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  mips_lite_pkg::reg_addr_t rs_addr_i,
    input  mips_lite_pkg::reg_addr_t rt_addr_i,
    output mips_lite_pkg::word_t     rs_data_o,
    output mips_lite_pkg::word_t     rt_data_o,
    input  mips_lite_pkg::wb_res_t   wr_i
);

    import mips_lite_pkg::*;

    word_t regs [`MIPS_REG_NUM];

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < `MIPS_REG_NUM; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_i.wr_en && wr_i.dest_addr != '0) begin
            regs[wr_i.dest_addr] <= wr_i.result;
        end
    end

    // r0 is hardwired
    assign rs_data_o = (rs_addr_i == '0) ? '0 : regs[rs_addr_i];
    assign rt_data_o = (rt_addr_i == '0) ? '0 : regs[rt_addr_i];

endmodule

`default_nettype wire

/* hdl/mips_lite_top.sv */
`timescale 1ns/1ns
`default_nettype none

module mips_lite_top (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  logic                     wb_cyc_i,
    input  logic                     wb_stb_i,
    input  logic                     wb_we_i,
    input  mips_lite_pkg::word_t     wb_dat_i,
    output logic                     wb_ack_o,
    output mips_lite_pkg::word_t     wb_dat_o,
    output logic                     wr_en_o,
    output mips_lite_pkg::reg_addr_t wr_addr_o,
    output mips_lite_pkg::word_t     wr_data_o
);

    import mips_lite_pkg::*;

    word_t     instr;
    logic      instr_vld;
    decoded_t  dec;
    reg_addr_t rf_rs_addr;
    reg_addr_t rf_rt_addr;
    word_t     rf_rs_data;
    word_t     rf_rt_data;
    ex_req_t   ex_req;
    wb_res_t   ex_fwd;
    wb_res_t   wb_res;  // feeds regfile, bypass and the result port

    instr_fetch_wb u_fetch (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .wb_cyc_i    (wb_cyc_i),
        .wb_stb_i    (wb_stb_i),
        .wb_we_i     (wb_we_i),
        .wb_dat_i    (wb_dat_i),
        .wb_ack_o    (wb_ack_o),
        .wb_dat_o    (wb_dat_o),
        .instr_o     (instr),
        .instr_vld_o (instr_vld)
    );

    id_decode u_decode (
        .instr_i     (instr),
        .instr_vld_i (instr_vld),
        .dec_o       (dec)
    );

    id_operand_sel u_opsel (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .dec_i        (dec),
        .rf_rs_addr_o (rf_rs_addr),
        .rf_rt_addr_o (rf_rt_addr),
        .rf_rs_data_i (rf_rs_data),
        .rf_rt_data_i (rf_rt_data),
        .ex_fwd_i     (ex_fwd),
        .wb_fwd_i     (wb_res),
        .req_o        (ex_req)
    );

    ex_stage u_ex (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .req_i    (ex_req),
        .ex_fwd_o (ex_fwd),
        .wb_res_o (wb_res)
    );

    regfile u_rf (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .rs_addr_i (rf_rs_addr),
        .rt_addr_i (rf_rt_addr),
        .rs_data_o (rf_rs_data),
        .rt_data_o (rf_rt_data),
        .wr_i      (wb_res)
    );

    assign wr_en_o   = wb_res.wr_en;
    assign wr_addr_o = wb_res.dest_addr;
    assign wr_data_o = wb_res.result;

endmodule

`default_nettype wire

/* verif/mips_lite_assertions.sv */
`timescale 1ns/1ns
`default_nettype none

module mips_lite_assertions (
    input logic                     clk_i,
    input logic                     rst_n_i,
    input logic                     wb_cyc_i,
    input logic                     wb_stb_i,
    input logic                     wb_ack_i,
    input logic                     wr_en_i,
    input mips_lite_pkg::reg_addr_t wr_addr_i
);

    int fail_cnt = 0;  // read by the testbench top

    ack_needs_req: assert property (@(posedge clk_i) wb_ack_i |-> (wb_cyc_i && wb_stb_i))
        else begin
            $error("wb_ack_o high without cyc and stb");
            fail_cnt++;
        end

    no_r0_write: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        wr_en_i |-> (wr_addr_i != '0))
        else begin
            $error("write-back enabled for register 0");
            fail_cnt++;
        end

    // sync reset, so the write enable is clear one edge later
    quiet_in_reset: assert property (@(posedge clk_i) !rst_n_i |=> !wr_en_i)
        else begin
            $error("wr_en_o high while in reset");
            fail_cnt++;
        end

endmodule

bind mips_lite_top mips_lite_assertions u_assert (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .wb_cyc_i  (wb_cyc_i),
    .wb_stb_i  (wb_stb_i),
    .wb_ack_i  (wb_ack_o),
    .wr_en_i   (wr_en_o),
    .wr_addr_i (wr_addr_o)
);

`default_nettype wire

/* verif/mips_lite_checker.sv */
`include "mips_lite_macros.svh"
`timescale 1ns/1ns
`default_nettype none

module mips_lite_checker (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  logic                     wb_cyc_i,
    input  logic                     wb_stb_i,
    input  logic                     wb_we_i,
    input  logic                     wb_ack_i,
    input  mips_lite_pkg::word_t     wb_dat_i,
    input  logic                     wr_en_i,
    input  mips_lite_pkg::reg_addr_t wr_addr_i,
    input  mips_lite_pkg::word_t     wr_data_i,
    output int                       err_cnt_o,
    output int                       pend_o,
    output int                       chk_cnt_o
);

    import mips_lite_pkg::*;

    typedef struct packed {
        int        due;   // cycle on which the write is sampled
        reg_addr_t addr;
        word_t     data;
    } exp_wr_t;

    word_t   model [`MIPS_REG_NUM];
    exp_wr_t exp_q [$];
    int      cycle;
    int      errs = 0;
    int      pend = 0;
    int      checked = 0;

    assign err_cnt_o = errs;
    assign pend_o    = pend;
    assign chk_cnt_o = checked;

    // ISA meaning of one word, a = value of rs, b = value of rt
    function automatic logic ref_exec(input word_t instr, input word_t a, input word_t b,
                                      output reg_addr_t dest, output word_t res);
        logic [5:0] op;
        logic [5:0] fn;
        logic [4:0] sh;
        word_t      zx;
        word_t      sx;
        logic       ok;
        op   = instr[31:26];
        fn   = instr[5:0];
        sh   = instr[10:6];
        zx   = {16'h0000, instr[15:0]};
        sx   = {{16{instr[15]}}, instr[15:0]};
        dest = (op == `OP_SPECIAL) ? instr[15:11] : instr[20:16];
        ok   = 1'b1;
        res  = '0;
        if (op == `OP_SPECIAL) begin
            case (fn)
                `FN_OR:   res = a | b;
                `FN_AND:  res = a & b;
                `FN_XOR:  res = a ^ b;
                `FN_NOR:  res = ~(a | b);
                `FN_SLL:  res = b << sh;
                `FN_SRL:  res = b >> sh;
                `FN_SRA:  res = $signed(b) >>> sh;
                `FN_SLLV: res = b << a[4:0];
                `FN_SRLV: res = b >> a[4:0];
                `FN_SRAV: res = $signed(b) >>> a[4:0];
                `FN_ADDU: res = a + b;
                `FN_SUBU: res = a - b;
                `FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                `FN_SLTU: res = (a < b) ? 32'd1 : 32'd0;
                default:  ok = 1'b0;  // mult, jr and the like
            endcase
        end else begin
            case (op)
                `OP_ORI:   res = a | zx;
                `OP_ANDI:  res = a & zx;
                `OP_XORI:  res = a ^ zx;
                `OP_LUI:   res = {instr[15:0], 16'h0000};
                `OP_ADDIU: res = a + sx;
                `OP_SLTI:  res = ($signed(a) < $signed(sx)) ? 32'd1 : 32'd0;
                `OP_SLTIU: res = (a < sx) ? 32'd1 : 32'd0;
                default:   ok = 1'b0;  // branches, loads
            endcase
        end
        return ok && (dest != '0);
    endfunction

    always @(posedge clk_i) begin : compare
        exp_wr_t   e;
        reg_addr_t dest;
        word_t     res;
        if (!rst_n_i) begin
            exp_q.delete();
            cycle = 0;
            for (int i = 0; i < `MIPS_REG_NUM; i++) begin
                model[i] = '0;
            end
        end else begin
            if (wr_en_i) begin
                if (exp_q.size() == 0) begin
                    $display("%0t: write-back to r%0d when none was expected", $time, wr_addr_i);
                    errs++;
                end else begin
                    e = exp_q.pop_front();
                    checked++;
                    if (wr_addr_i !== e.addr) begin
                        $display("[FAIL] %0t wr_addr_o expected %0d got %0d",
                                 $time, e.addr, wr_addr_i);
                        errs++;
                    end
                    if (wr_data_i !== e.data) begin
                        $display("[FAIL] %0t wr_data_o expected %h got %h",
                                 $time, e.data, wr_data_i);
                        errs++;
                    end
                    if (cycle != e.due) begin
                        $display("%0t: write to r%0d came at cycle %0d instead of cycle %0d",
                                 $time, e.addr, cycle, e.due);
                        errs++;
                    end
                end
            end else if (exp_q.size() != 0 && exp_q[0].due <= cycle) begin
                e = exp_q.pop_front();
                $display("%0t: expected write to r%0d never appeared", $time, e.addr);
                errs++;
            end
            if (wb_cyc_i && wb_stb_i && wb_we_i && wb_ack_i) begin
                if (ref_exec(wb_dat_i, model[wb_dat_i[25:21]], model[wb_dat_i[20:16]],
                             dest, res)) begin
                    model[dest] = res;
                    e.due  = cycle + 3;  // two cycles of latency, seen on the third edge
                    e.addr = dest;
                    e.data = res;
                    exp_q.push_back(e);
                end
            end
            cycle++;
        end
        pend = exp_q.size();
    end

endmodule

`default_nettype wire

/* verif/tb_mips_lite.sv */
`include "mips_lite_macros.svh"
`timescale 1ns/1ns
`default_nettype none

module tb_mips_lite;

    import mips_lite_pkg::*;

    localparam int WAIT_MAX = 50;  // cycles allowed for any single wait

    logic      clk;
    logic      rst_n;
    logic      wb_cyc;
    logic      wb_stb;
    logic      wb_we;
    word_t     wb_dat;
    logic      wb_ack;
    word_t     wb_rdat;
    logic      wr_en;
    reg_addr_t wr_addr;
    word_t     wr_data;
    int        chk_err;
    int        pend;
    int        chk_cnt;
    int        tb_err;
    int        test_num;
    int        err_mark;
    word_t     rnd;

    mips_lite_top UUT (
        .clk_i     (clk),
        .rst_n_i   (rst_n),
        .wb_cyc_i  (wb_cyc),
        .wb_stb_i  (wb_stb),
        .wb_we_i   (wb_we),
        .wb_dat_i  (wb_dat),
        .wb_ack_o  (wb_ack),
        .wb_dat_o  (wb_rdat),
        .wr_en_o   (wr_en),
        .wr_addr_o (wr_addr),
        .wr_data_o (wr_data)
    );

    mips_lite_checker u_checker (
        .clk_i     (clk),
        .rst_n_i   (rst_n),
        .wb_cyc_i  (wb_cyc),
        .wb_stb_i  (wb_stb),
        .wb_we_i   (wb_we),
        .wb_ack_i  (wb_ack),
        .wb_dat_i  (wb_dat),
        .wr_en_i   (wr_en),
        .wr_addr_i (wr_addr),
        .wr_data_i (wr_data),
        .err_cnt_o (chk_err),
        .pend_o    (pend),
        .chk_cnt_o (chk_cnt)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic word_t rtype(input logic [5:0] fn, input reg_addr_t rs,
                                    input reg_addr_t rt, input reg_addr_t rd,
                                    input logic [4:0] sh);
        return {`OP_SPECIAL, rs, rt, rd, sh, fn};
    endfunction

    function automatic word_t itype(input logic [5:0] op, input reg_addr_t rs,
                                    input reg_addr_t rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic int total_errors();
        return tb_err + chk_err + UUT.u_assert.fail_cnt;
    endfunction

    // called 1 ns after an edge, returns 1 ns after the accepting edge
    task automatic bus_write(input word_t instr);
        int waits;
        waits  = 0;
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = 1'b1;
        wb_dat = instr;
        #1;
        while (!wb_ack && waits < WAIT_MAX) begin
            @(posedge clk);
            #1;
            waits++;
        end
        if (!wb_ack) begin
            $display("%0t: no wb_ack_o for instruction %h", $time, instr);
            tb_err++;
        end else if (waits != 0) begin
            $display("%0t: wb_ack_o came %0d cycles after the request", $time, waits);
            tb_err++;
        end
        @(posedge clk);
        #1;
    endtask

    // wb_dat_i carries a live instruction, which a read must not execute
    task automatic bus_read(input word_t junk);
        int waits;
        waits  = 0;
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = 1'b0;
        wb_dat = junk;
        #1;
        while (!wb_ack && waits < WAIT_MAX) begin
            @(posedge clk);
            #1;
            waits++;
        end
        if (!wb_ack) begin
            $display("%0t: no wb_ack_o for a bus read", $time);
            tb_err++;
        end else if (wb_rdat !== 32'h0000_0000) begin
            $display("[FAIL] %0t wb_dat_o expected %h got %h", $time, 32'h0000_0000, wb_rdat);
            tb_err++;
        end
        @(posedge clk);
        #1;
    endtask

    task automatic release_bus();
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        wb_dat = '0;
    endtask

    task automatic load_const(input reg_addr_t r, input word_t val);
        bus_write(itype(`OP_LUI, 5'd0, r, val[31:16]));
        bus_write(itype(`OP_ORI, r, r, val[15:0]));
    endtask

    task automatic wait_drain();
        int waits;
        waits = 0;
        release_bus();
        repeat (4) @(posedge clk);  // room for a stray write after the last word
        #1;
        while (pend != 0 && waits < WAIT_MAX) begin
            @(posedge clk);
            #1;
            waits++;
        end
        if (pend != 0) begin
            $display("%0t: %0d expected writes still pending at timeout", $time, pend);
            tb_err++;
        end
    endtask

    task automatic report_test(input string name);
        int errs;
        wait_drain();
        errs = total_errors() - err_mark;
        test_num++;
        $display("test %0d %s: %0d errors", test_num, name, errs);
        err_mark = total_errors();
    endtask

    initial begin : stimulus
        int waits;
        int d;
        int s;
        int t;
        void'($urandom(32'h14ea));
        rst_n    = 1'b0;
        tb_err   = 0;
        test_num = 0;
        err_mark = 0;
        release_bus();
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // idle bus after reset
        waits = 0;
        while (waits < 4) begin
            @(posedge clk);
            #1;
            if (wb_ack !== 1'b0 || wr_en !== 1'b0) begin
                $display("[FAIL] %0t wb_ack_o/wr_en_o expected 0/0 got %b/%b",
                         $time, wb_ack, wr_en);
                tb_err++;
            end
            waits++;
        end
        for (int i = 1; i < 8; i++) begin
            bus_write(rtype(`FN_OR, reg_addr_t'(i + 8), 5'd0, reg_addr_t'(i), 5'd0));
        end
        report_test("reset_read_zero");

        load_const(5'd1, $urandom());
        load_const(5'd2, $urandom());
        rnd = $urandom();
        bus_write(rtype(`FN_OR, 5'd1, 5'd2, 5'd3, 5'd0));
        bus_write(rtype(`FN_AND, 5'd1, 5'd2, 5'd4, 5'd0));
        bus_write(rtype(`FN_XOR, 5'd1, 5'd2, 5'd5, 5'd0));
        bus_write(rtype(`FN_NOR, 5'd1, 5'd2, 5'd6, 5'd0));
        bus_write(itype(`OP_ORI, 5'd1, 5'd7, rnd[15:0]));
        bus_write(itype(`OP_ANDI, 5'd1, 5'd8, rnd[31:16]));
        bus_write(itype(`OP_XORI, 5'd2, 5'd9, rnd[15:0]));
        bus_write(itype(`OP_LUI, 5'd0, 5'd10, rnd[31:16]));
        report_test("logic_ops");

        load_const(5'd2, $urandom() | 32'h8000_0000);  // negative, for sra
        for (int i = 0; i < 4; i++) begin
            rnd = $urandom();
            load_const(5'd3, rnd);
            bus_write(rtype(`FN_SLL, 5'd0, 5'd2, 5'd11, rnd[4:0]));
            bus_write(rtype(`FN_SRL, 5'd0, 5'd2, 5'd12, rnd[9:5]));
            bus_write(rtype(`FN_SRA, 5'd0, 5'd2, 5'd13, rnd[14:10]));
            bus_write(rtype(`FN_SLLV, 5'd3, 5'd2, 5'd14, 5'd0));
            bus_write(rtype(`FN_SRLV, 5'd3, 5'd2, 5'd15, 5'd0));
            bus_write(rtype(`FN_SRAV, 5'd3, 5'd2, 5'd16, 5'd0));
        end
        report_test("shifts");

        load_const(5'd4, 32'hffff_ffff);
        load_const(5'd5, $urandom());
        bus_write(rtype(`FN_ADDU, 5'd4, 5'd4, 5'd17, 5'd0));  // wraps
        bus_write(rtype(`FN_ADDU, 5'd4, 5'd5, 5'd18, 5'd0));
        bus_write(rtype(`FN_SUBU, 5'd0, 5'd5, 5'd19, 5'd0));
        bus_write(rtype(`FN_SUBU, 5'd5, 5'd4, 5'd20, 5'd0));
        bus_write(itype(`OP_ADDIU, 5'd5, 5'd21, 16'h8001));
        bus_write(rtype(`FN_SLT, 5'd4, 5'd5, 5'd22, 5'd0));
        bus_write(rtype(`FN_SLTU, 5'd4, 5'd5, 5'd23, 5'd0));
        bus_write(itype(`OP_SLTI, 5'd4, 5'd24, 16'h0001));
        bus_write(itype(`OP_SLTIU, 5'd5, 5'd25, 16'hffff));  // compares against all ones
        report_test("arith_compare");

        load_const(5'd26, $urandom());
        load_const(5'd27, $urandom());
        load_const(5'd28, $urandom());
        for (int i = 0; i < 12; i++) begin
            rnd = $urandom();
            d = 26 + i % 3;
            s = 26 + (i + 2) % 3;  // written one word earlier
            t = 26 + (i + 1) % 3;  // written two words earlier
            case (rnd[1:0])
                2'd0: bus_write(rtype(`FN_ADDU, reg_addr_t'(s), reg_addr_t'(t),
                                      reg_addr_t'(d), 5'd0));
                2'd1: bus_write(rtype(`FN_SUBU, reg_addr_t'(s), reg_addr_t'(t),
                                      reg_addr_t'(d), 5'd0));
                2'd2: bus_write(rtype(`FN_XOR, reg_addr_t'(s), reg_addr_t'(t),
                                      reg_addr_t'(d), 5'd0));
                default: bus_write(itype(`OP_ADDIU, reg_addr_t'(s), reg_addr_t'(d),
                                         rnd[31:16]));
            endcase
        end
        report_test("forwarding_chain");

        bus_write(itype(6'b000100, 5'd1, 5'd2, 16'h0004));      // beq
        bus_write(itype(6'b100011, 5'd1, 5'd9, 16'h0010));      // lw
        bus_write(rtype(6'b011000, 5'd1, 5'd2, 5'd0, 5'd0));    // mult
        bus_write(rtype(`FN_ADDU, 5'd1, 5'd2, 5'd0, 5'd0));
        bus_write(itype(`OP_ORI, 5'd1, 5'd0, 16'h1234));
        bus_read(itype(`OP_ORI, 5'd1, 5'd9, 16'h5a5a));         // reads return zero
        bus_write(rtype(`FN_OR, 5'd9, 5'd0, 5'd29, 5'd0));     // r9 and r0 untouched
        report_test("dropped_encodings");

        $display("tests %0d, checked writes %0d, errors %0d", test_num, chk_cnt, total_errors());
        if (total_errors() == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* mips_lite.f */
+incdir+include
hdl/mips_lite_pkg.sv
hdl/instr_fetch_wb.sv
hdl/id_decode.sv
hdl/id_operand_sel.sv
hdl/ex_stage.sv
hdl/regfile.sv
hdl/mips_lite_top.sv
verif/mips_lite_assertions.sv
verif/mips_lite_checker.sv
verif/tb_mips_lite.sv
